// ==== common/lsu_pkg.sv ====
`default_nettype none

package lsu_pkg;

    // load/store opcodes presented by the execute stage
    typedef enum logic [3:0] {
        LS_NONE = 4'd0,
        LS_LB   = 4'd1,
        LS_LBU  = 4'd2,
        LS_LH   = 4'd3,
        LS_LHU  = 4'd4,
        LS_LW   = 4'd5,
        LS_LWL  = 4'd6,
        LS_LWR  = 4'd7,
        LS_SB   = 4'd8,
        LS_SH   = 4'd9,
        LS_SW   = 4'd10,
        LS_SWL  = 4'd11,
        LS_SWR  = 4'd12
    } ls_op_t;

    // memory stage controller states
    typedef enum logic [1:0] {
        ST_IDLE   = 2'd0,
        ST_ACCESS = 2'd1,
        ST_RESP   = 2'd2
    } ctrl_state_t;

    typedef logic [31:0] word_t;

    // 256 words of data RAM
    localparam int RAM_ADDR_BITS = 8;
    localparam int RAM_WORDS     = 1 << RAM_ADDR_BITS;

    // byte lanes per word
    localparam int WORD_BYTES = 4;

endpackage

`default_nettype wire

// ==== lsu/store_formatter.sv ====
`timescale 1ns/1ps
`default_nettype none

module store_formatter import lsu_pkg::*; (
    input  ls_op_t                op,
    input  word_t                 addr,
    input  word_t                 rt_data,
    output logic [WORD_BYTES-1:0] wen,
    output word_t                 wdata,
    output logic                  misalign
);

    logic [1:0] off;

    assign off = addr[1:0];

    always_comb begin
        wen      = '0;
        wdata    = '0;
        misalign = 1'b0;
        case (op)
            LS_SB: begin
                wen   = 4'b0001 << off;
                wdata = {WORD_BYTES{rt_data[7:0]}};
            end
            LS_SH: begin
                // odd halfword address is an ades
                misalign = off[0];
                wen      = off[1] ? 4'b1100 : 4'b0011;
                wdata    = {2{rt_data[15:0]}};
            end
            LS_SW: begin
                misalign = |off;
                wen      = 4'b1111;
                wdata    = rt_data;
            end
            LS_SWL: begin
                // high bytes of rt go down to the addressed byte
                case (off)
                    2'b00: begin
                        wen   = 4'b0001;
                        wdata = {24'h0, rt_data[31:24]};
                    end
                    2'b01: begin
                        wen   = 4'b0011;
                        wdata = {16'h0, rt_data[31:16]};
                    end
                    2'b10: begin
                        wen   = 4'b0111;
                        wdata = {8'h0, rt_data[31:8]};
                    end
                    default: begin
                        wen   = 4'b1111;
                        wdata = rt_data;
                    end
                endcase
            end
            LS_SWR: begin
                // low bytes of rt go up from the addressed byte
                case (off)
                    2'b00: begin
                        wen   = 4'b1111;
                        wdata = rt_data;
                    end
                    2'b01: begin
                        wen   = 4'b1110;
                        wdata = {rt_data[23:0], 8'h0};
                    end
                    2'b10: begin
                        wen   = 4'b1100;
                        wdata = {rt_data[15:0], 16'h0};
                    end
                    default: begin
                        wen   = 4'b1000;
                        wdata = {rt_data[7:0], 24'h0};
                    end
                endcase
            end
            default: begin
                wen = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== lsu/load_aligner.sv ====
`timescale 1ns/1ps
`default_nettype none

module load_aligner import lsu_pkg::*; (
    input  ls_op_t op,
    input  word_t  addr,
    input  word_t  rt_data,
    input  word_t  rdata,
    output word_t  data,
    output logic   misalign
);

    logic [1:0]  off;
    logic [7:0]  sel_byte;
    logic [15:0] sel_half;

    assign off = addr[1:0];

    // addressed byte and halfword of the RAM word
    always_comb begin
        case (off)
            2'b00:   sel_byte = rdata[7:0];
            2'b01:   sel_byte = rdata[15:8];
            2'b10:   sel_byte = rdata[23:16];
            default: sel_byte = rdata[31:24];
        endcase
    end

    assign sel_half = off[1] ? rdata[31:16] : rdata[15:0];

    always_comb begin
        case (op)
            LS_LH, LS_LHU: misalign = off[0];
            LS_LW:         misalign = |off;
            default:       misalign = 1'b0;
        endcase
    end

    always_comb begin
        data = '0;
        case (op)
            LS_LB:  data = {{24{sel_byte[7]}}, sel_byte};
            LS_LBU: data = {24'h0, sel_byte};
            LS_LH:  data = {{16{sel_half[15]}}, sel_half};
            LS_LHU: data = {16'h0, sel_half};
            LS_LW:  data = rdata;
            LS_LWL: begin
                // RAM bytes fill rt from the top down
                case (off)
                    2'b00:   data = {rdata[7:0], rt_data[23:0]};
                    2'b01:   data = {rdata[15:0], rt_data[15:0]};
                    2'b10:   data = {rdata[23:0], rt_data[7:0]};
                    default: data = rdata;
                endcase
            end
            LS_LWR: begin
                // RAM bytes fill rt from the bottom up
                case (off)
                    2'b00:   data = rdata;
                    2'b01:   data = {rt_data[31:24], rdata[31:8]};
                    2'b10:   data = {rt_data[31:16], rdata[31:16]};
                    default: data = {rt_data[31:8], rdata[31:24]};
                endcase
            end
            default: begin
                data = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== lsu/ls_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module ls_controller import lsu_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  req,
    input  logic                  prior_exc,
    input  ls_op_t                op,
    input  word_t                 addr,
    input  word_t                 rt_data,
    output logic                  ack,
    output ls_op_t                cur_op,
    output word_t                 cur_addr,
    output word_t                 cur_rt,
    input  logic [WORD_BYTES-1:0] st_wen,
    input  word_t                 st_wdata,
    input  logic                  st_misalign,
    input  word_t                 ld_data,
    input  logic                  ld_misalign,
    output logic                  ram_en,
    output logic [WORD_BYTES-1:0] ram_wen,
    output word_t                 ram_addr,
    output word_t                 ram_wdata,
    output word_t                 rd_data,
    output logic                  adel,
    output logic                  ades,
    output logic                  exc
);

    ctrl_state_t state;
    logic        cur_exc;
    logic        resp_first;
    word_t       rd_q;
    word_t       resp_data;
    logic        accept;

    assign accept = (state == ST_IDLE) && req;

    // request fields and the earlier exception are sampled on accept
    always_ff @(posedge clk) begin
        if (reset) begin
            cur_op  <= LS_NONE;
            cur_exc <= 1'b0;
        end else if (accept) begin
            cur_op  <= op;
            cur_exc <= prior_exc;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            cur_addr <= addr;
            cur_rt   <= rt_data;
        end
    end

    // no RAM access on an address error or an earlier exception
    assign ram_en = (state == ST_ACCESS) && (cur_op != LS_NONE) && !cur_exc &&
                    !st_misalign && !ld_misalign;
    assign ram_wen   = {WORD_BYTES{ram_en}} & st_wen;
    assign ram_addr  = cur_addr;
    assign ram_wdata = st_wdata;

    // RAM read word is valid in the first response cycle only
    assign resp_data = exc ? '0 : ld_data;
    assign rd_data   = resp_first ? resp_data : rd_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= ST_IDLE;
            ack        <= 1'b0;
            adel       <= 1'b0;
            ades       <= 1'b0;
            exc        <= 1'b0;
            resp_first <= 1'b0;
            rd_q       <= '0;
        end else begin
            resp_first <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (req) begin
                        state <= ST_ACCESS;
                    end
                end
                ST_ACCESS: begin
                    state      <= ST_RESP;
                    ack        <= 1'b1;
                    adel       <= ld_misalign;
                    ades       <= st_misalign;
                    exc        <= cur_exc | ld_misalign | st_misalign;
                    resp_first <= 1'b1;
                end
                ST_RESP: begin
                    if (resp_first) begin
                        rd_q <= resp_data;
                    end
                    // hold the response until the requester lets go
                    if (!req) begin
                        ack   <= 1'b0;
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                    ack   <= 1'b0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hw/data_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module data_ram import lsu_pkg::*; (
    input  logic                  clk,
    input  logic                  en,
    input  logic [WORD_BYTES-1:0] wen,
    input  word_t                 addr,
    input  word_t                 wdata,
    output word_t                 rdata
);

    word_t mem [RAM_WORDS];

    logic [RAM_ADDR_BITS-1:0] idx;

    // word address with the byte offset dropped
    assign idx = addr[RAM_ADDR_BITS+1:2];

    always_ff @(posedge clk) begin
        if (en) begin
            // old contents come out on a write
            rdata <= mem[idx];
            for (int b = 0; b < WORD_BYTES; b++) begin
                if (wen[b]) begin
                    mem[idx][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/lsu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_top import lsu_pkg::*; (
    input  logic   clk,
    input  logic   reset,
    input  logic   req,
    input  logic   prior_exc,
    input  ls_op_t op,
    input  word_t  addr,
    input  word_t  rt_data,
    output logic   ack,
    output logic   adel,
    output logic   ades,
    output logic   exc,
    output word_t  rd_data
);

    ls_op_t                cur_op;
    word_t                 cur_addr;
    word_t                 cur_rt;
    logic [WORD_BYTES-1:0] st_wen;
    word_t                 st_wdata;
    logic                  st_misalign;
    word_t                 ld_data;
    logic                  ld_misalign;
    logic                  ram_en;
    logic [WORD_BYTES-1:0] ram_wen;
    word_t                 ram_addr;
    word_t                 ram_wdata;
    word_t                 ram_rdata;

    ls_controller u_ctrl (
        .clk         (clk),
        .reset       (reset),
        .req         (req),
        .prior_exc   (prior_exc),
        .op          (op),
        .addr        (addr),
        .rt_data     (rt_data),
        .ack         (ack),
        .cur_op      (cur_op),
        .cur_addr    (cur_addr),
        .cur_rt      (cur_rt),
        .st_wen      (st_wen),
        .st_wdata    (st_wdata),
        .st_misalign (st_misalign),
        .ld_data     (ld_data),
        .ld_misalign (ld_misalign),
        .ram_en      (ram_en),
        .ram_wen     (ram_wen),
        .ram_addr    (ram_addr),
        .ram_wdata   (ram_wdata),
        .rd_data     (rd_data),
        .adel        (adel),
        .ades        (ades),
        .exc         (exc)
    );

    // store and load paths work side by side on the registered request
    store_formatter u_store (
        .op       (cur_op),
        .addr     (cur_addr),
        .rt_data  (cur_rt),
        .wen      (st_wen),
        .wdata    (st_wdata),
        .misalign (st_misalign)
    );

    load_aligner u_load (
        .op       (cur_op),
        .addr     (cur_addr),
        .rt_data  (cur_rt),
        .rdata    (ram_rdata),
        .data     (ld_data),
        .misalign (ld_misalign)
    );

    data_ram u_ram (
        .clk   (clk),
        .en    (ram_en),
        .wen   (ram_wen),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

endmodule

`default_nettype wire

// ==== bench/lsu_tb_tasks.svh ====
task automatic fail_run(input string why);
    $display("%s", why);
    $display("CHECKS FAILED");
    $fatal(1, "run stopped at the first failure");
endtask

task automatic check_word(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
        fail_run($sformatf("FAILED at %0t: %s expected %h got %h", $time, name, exp, act));
    end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
        fail_run($sformatf("FAILED at %0t: %s expected %b got %b", $time, name, exp, act));
    end
endtask

// one four-phase transaction with req held for hold_i extra cycles after ack
task automatic ls_request(input ls_op_t op_i, input word_t addr_i, input word_t rt_i,
                          input logic pexc_i, input int hold_i, output word_t data_o,
                          output logic adel_o, output logic ades_o, output logic exc_o);
    @(negedge clk);
    if (ack !== 1'b0) begin
        fail_run("ack was still high when a new request was about to start");
    end
    op        = op_i;
    addr      = addr_i;
    rt_data   = rt_i;
    prior_exc = pexc_i;
    req       = 1'b1;
    // the first edge accepts the request, the second one raises ack
    @(posedge clk);
    @(negedge clk);
    if (ack !== 1'b0) begin
        fail_run("ack rose at the edge that accepted the request, too early");
    end
    @(posedge clk);
    @(negedge clk);
    if (ack !== 1'b1) begin
        fail_run("ack did not rise at the second edge after req was raised");
    end
    data_o = rd_data;
    adel_o = adel;
    ades_o = ades;
    exc_o  = exc;
    repeat (hold_i) begin
        @(posedge clk);
        @(negedge clk);
        if (ack !== 1'b1) begin
            fail_run("ack fell while req was still held high");
        end
        check_word("rd_data", data_o, rd_data);
        check_bit("exc", exc_o, exc);
    end
    req = 1'b0;
    @(posedge clk);
    @(negedge clk);
    if (ack !== 1'b0) begin
        fail_run("ack did not fall at the first edge after req was dropped");
    end
endtask

// ==== bench/lsu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_tb import lsu_pkg::*; ();

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 5;
    localparam int NUM_TRANS    = 94;

    logic   clk;
    logic   reset;
    logic   req;
    logic   prior_exc;
    ls_op_t op;
    word_t  addr;
    word_t  rt_data;
    logic   ack;
    logic   adel;
    logic   ades;
    logic   exc;
    word_t  rd_data;

    integer seed;
    // expected contents of every word the tests have written
    word_t  model_mem [RAM_WORDS];

    lsu_top dut (
        .clk       (clk),
        .reset     (reset),
        .req       (req),
        .prior_exc (prior_exc),
        .op        (op),
        .addr      (addr),
        .rt_data   (rt_data),
        .ack       (ack),
        .adel      (adel),
        .ades      (ades),
        .exc       (exc),
        .rd_data   (rd_data)
    );

    `include "lsu_tb_tasks.svh"

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic word_t next_rand();
        return $random(seed);
    endfunction

    function automatic logic expect_adel(ls_op_t op_i, int k);
        return ((op_i == LS_LH || op_i == LS_LHU) && k % 2 == 1) || (op_i == LS_LW && k != 0);
    endfunction

    function automatic logic expect_ades(ls_op_t op_i, int k);
        return (op_i == LS_SH && k % 2 == 1) || (op_i == LS_SW && k != 0);
    endfunction

    // memory word after a store at byte offset k in little-endian lanes
    function automatic word_t apply_store(ls_op_t op_i, int k, word_t rt_i, word_t w);
        word_t r;
        r = w;
        for (int i = 0; i < WORD_BYTES; i++) begin
            case (op_i)
                LS_SB:   if (i == k) r[8*i +: 8] = rt_i[7:0];
                LS_SH:   if (i / 2 == k / 2) r[8*i +: 8] = rt_i[8*(i % 2) +: 8];
                LS_SW:   r[8*i +: 8] = rt_i[8*i +: 8];
                LS_SWL:  if (i <= k) r[8*i +: 8] = rt_i[8*(3 - k + i) +: 8];
                LS_SWR:  if (i >= k) r[8*i +: 8] = rt_i[8*(i - k) +: 8];
                default: r = w;
            endcase
        end
        return r;
    endfunction

    function automatic word_t predict_load(ls_op_t op_i, int k, word_t rt_i, word_t w);
        word_t       r;
        logic [7:0]  b;
        logic [15:0] h;
        b = w[8*k +: 8];
        h = w[16*(k / 2) +: 16];
        r = rt_i;
        case (op_i)
            LS_LB:   r = {{24{b[7]}}, b};
            LS_LBU:  r = {24'h0, b};
            LS_LH:   r = {{16{h[15]}}, h};
            LS_LHU:  r = {16'h0, h};
            LS_LW:   r = w;
            LS_LWL:  for (int j = 3 - k; j < 4; j++) r[8*j +: 8] = w[8*(j - 3 + k) +: 8];
            LS_LWR:  for (int j = 0; j <= 3 - k; j++) r[8*j +: 8] = w[8*(j + k) +: 8];
            default: r = '0;
        endcase
        return r;
    endfunction

    task automatic run_and_check(input ls_op_t op_i, input word_t addr_i, input word_t rt_i,
                                 input logic pexc_i, input int hold_i);
        logic [RAM_ADDR_BITS-1:0] idx;
        int    k;
        logic  exp_adel;
        logic  exp_ades;
        logic  exp_exc;
        word_t exp_data;
        word_t got_data;
        logic  got_adel;
        logic  got_ades;
        logic  got_exc;
        idx      = addr_i[RAM_ADDR_BITS+1:2];
        k        = int'(addr_i[1:0]);
        exp_adel = expect_adel(op_i, k);
        exp_ades = expect_ades(op_i, k);
        exp_exc  = pexc_i | exp_adel | exp_ades;
        exp_data = exp_exc ? '0 : predict_load(op_i, k, rt_i, model_mem[idx]);
        ls_request(op_i, addr_i, rt_i, pexc_i, hold_i, got_data, got_adel, got_ades, got_exc);
        check_bit("adel", exp_adel, got_adel);
        check_bit("ades", exp_ades, got_ades);
        check_bit("exc", exp_exc, got_exc);
        check_word("rd_data", exp_data, got_data);
        if (!exp_exc) begin
            model_mem[idx] = apply_store(op_i, k, rt_i, model_mem[idx]);
        end
    endtask

    task automatic test_reset_values();
        check_bit("ack", 1'b0, ack);
        check_bit("adel", 1'b0, adel);
        check_bit("ades", 1'b0, ades);
        check_bit("exc", 1'b0, exc);
        check_word("rd_data", '0, rd_data);
    endtask

    task automatic test_word_access();
        for (int i = 0; i < 8; i++) run_and_check(LS_SW, word_t'(4 * i), next_rand(), 1'b0, 0);
        for (int i = 0; i < 8; i++) run_and_check(LS_LW, word_t'(4 * i), next_rand(), 1'b0, 0);
    endtask

    task automatic test_byte_half();
        word_t rnd;
        run_and_check(LS_SW, 32'h40, next_rand(), 1'b0, 0);
        // odd lanes get negative bytes, even lanes positive ones
        for (int k = 0; k < 4; k++) begin
            rnd    = next_rand();
            rnd[7] = (k % 2 == 1);
            run_and_check(LS_SB, 32'h40 + word_t'(k), rnd, 1'b0, 0);
            run_and_check(LS_LW, 32'h40, next_rand(), 1'b0, 0);
        end
        for (int k = 0; k < 4; k++) begin
            run_and_check(LS_LB, 32'h40 + word_t'(k), next_rand(), 1'b0, 0);
            run_and_check(LS_LBU, 32'h40 + word_t'(k), next_rand(), 1'b0, 0);
        end
        for (int k = 0; k < 4; k += 2) begin
            rnd     = next_rand();
            rnd[15] = (k == 2);
            run_and_check(LS_SH, 32'h40 + word_t'(k), rnd, 1'b0, 0);
            run_and_check(LS_LH, 32'h40 + word_t'(k), next_rand(), 1'b0, 0);
            run_and_check(LS_LHU, 32'h40 + word_t'(k), next_rand(), 1'b0, 0);
            run_and_check(LS_LW, 32'h40, next_rand(), 1'b0, 0);
        end
    endtask

    task automatic test_partial_store();
        for (int k = 0; k < 4; k++) begin
            run_and_check(LS_SW, 32'h80, next_rand(), 1'b0, 0);
            run_and_check(LS_SWL, 32'h80 + word_t'(k), next_rand(), 1'b0, 0);
            run_and_check(LS_LW, 32'h80, next_rand(), 1'b0, 0);
            run_and_check(LS_SW, 32'h80, next_rand(), 1'b0, 0);
            run_and_check(LS_SWR, 32'h80 + word_t'(k), next_rand(), 1'b0, 0);
            run_and_check(LS_LW, 32'h80, next_rand(), 1'b0, 0);
        end
    endtask

    task automatic test_partial_load();
        run_and_check(LS_SW, 32'hc0, next_rand(), 1'b0, 0);
        for (int k = 0; k < 4; k++) begin
            run_and_check(LS_LWL, 32'hc0 + word_t'(k), next_rand(), 1'b0, 0);
            run_and_check(LS_LWR, 32'hc0 + word_t'(k), next_rand(), 1'b0, 0);
        end
    endtask

    task automatic test_address_errors();
        run_and_check(LS_SW, 32'h100, next_rand(), 1'b0, 0);
        for (int k = 1; k < 4; k++) begin
            run_and_check(LS_LW, 32'h100 + word_t'(k), next_rand(), 1'b0, 0);
            run_and_check(LS_SW, 32'h100 + word_t'(k), next_rand(), 1'b0, 0);
        end
        run_and_check(LS_LH, 32'h101, next_rand(), 1'b0, 0);
        run_and_check(LS_LHU, 32'h103, next_rand(), 1'b0, 0);
        run_and_check(LS_SH, 32'h103, next_rand(), 1'b0, 0);
        run_and_check(LS_LW, 32'h100, next_rand(), 1'b0, 0);
    endtask

    task automatic test_prior_exception();
        run_and_check(LS_SW, 32'h140, next_rand(), 1'b0, 0);
        run_and_check(LS_SW, 32'h140, next_rand(), 1'b1, 0);
        run_and_check(LS_SB, 32'h141, next_rand(), 1'b1, 0);
        run_and_check(LS_LW, 32'h140, next_rand(), 1'b1, 0);
        run_and_check(LS_LW, 32'h140, next_rand(), 1'b0, 0);
    endtask

    task automatic test_back_pressure();
        run_and_check(LS_SW, 32'h180, next_rand(), 1'b0, 0);
        run_and_check(LS_LW, 32'h180, next_rand(), 1'b0, 6);
        run_and_check(LS_SB, 32'h181, next_rand(), 1'b0, 3);
        run_and_check(LS_LW, 32'h180, next_rand(), 1'b0, 4);
    endtask

    // generous bound of twenty cycles per transaction
    initial begin
        #(CLK_PERIOD * (NUM_TRANS * 20 + RESET_CYCLES));
        fail_run("watchdog expired before the test sequence finished");
    end

    initial begin
        $timeformat(-9, 0, " ns", 0);
        seed      = 32'h5788fbd0;
        clk       = 1'b0;
        reset     = 1'b1;
        req       = 1'b0;
        prior_exc = 1'b0;
        op        = LS_NONE;
        addr      = '0;
        rt_data   = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        test_reset_values();
        test_word_access();
        test_byte_half();
        test_partial_store();
        test_partial_load();
        test_address_errors();
        test_prior_exception();
        test_back_pressure();
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+bench
common/lsu_pkg.sv
lsu/store_formatter.sv
lsu/load_aligner.sv
lsu/ls_controller.sv
hw/data_ram.sv
hw/lsu_top.sv
bench/lsu_tb.sv

// ==== Makefile ====
TOP := lsu_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f compile.f --top-module $(TOP)

sim:
	verilator --binary --timing -f compile.f --top-module $(TOP) --Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
